// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = dcache_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/dcache_checker.sv
`timescale 1ns/100ps

module dcache_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  logic              req_ready_i,
    input  dcache_pkg::addr_t req_addr_i,
    input  dcache_pkg::strb_t req_wstrb_i,
    input  dcache_pkg::word_t req_wdata_i,
    input  logic              resp_valid_i,
    input  dcache_pkg::word_t resp_rdata_i,
    input  logic              awvalid_i,
    input  logic              awready_i,
    input  dcache_pkg::addr_t awaddr_i,
    input  logic              wvalid_i,
    input  logic              wready_i,
    input  dcache_pkg::word_t wdata_i,
    input  dcache_pkg::strb_t wstrb_i,
    output int                check_count_o,
    output int                error_count_o,
    output int                resp_count_o
);

    typedef struct packed {
        dcache_pkg::addr_t addr;
        dcache_pkg::strb_t strb;
        dcache_pkg::word_t data;
        dcache_pkg::word_t expected;
        logic [31:0]       cycle;
        logic              must_hit;
    } pending_t;

    pending_t          pending [$];
    pending_t          head;
    pending_t          incoming;
    dcache_pkg::word_t shadow [logic [29:0]];
    logic [31:0]       cycle;
    logic [27:0]       last_line;
    logic              last_valid;
    dcache_pkg::addr_t beat_addr;
    dcache_pkg::word_t beat_data;
    dcache_pkg::strb_t beat_strb;
    logic              aw_seen;
    logic              w_seen;

    // memory contents before any store
    function automatic dcache_pkg::word_t initial_word(dcache_pkg::addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic dcache_pkg::word_t expected_word(dcache_pkg::addr_t addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return initial_word(addr);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(dcache_pkg::word_t old,
                                                      dcache_pkg::word_t data,
                                                      dcache_pkg::strb_t strb);
        dcache_pkg::word_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    task automatic report_error(string msg);
        error_count_o++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            pending.delete();
            check_count_o = 0;
            error_count_o = 0;
            resp_count_o  = 0;
            last_valid    = 1'b0;
            aw_seen       = 1'b0;
            w_seen        = 1'b0;
        end else begin
            // the response of this edge is retired before a new acceptance
            if (resp_valid_i) begin
                if (pending.size() == 0) begin
                    report_error("response with no request pending");
                end else begin
                    head = pending.pop_front();
                    resp_count_o++;
                    check_count_o++;
                    if (head.strb == '0 && resp_rdata_i !== head.expected) begin
                        report_error($sformatf("load %h returned %h, expected %h",
                                               head.addr, resp_rdata_i, head.expected));
                    end
                    if (head.strb != '0) begin
                        shadow[head.addr[31:2]] = merge_bytes(expected_word(head.addr),
                                                              head.data, head.strb);
                    end
                    if (head.must_hit && cycle != head.cycle + 1) begin
                        report_error($sformatf("load %h to a resident line answered late",
                                               head.addr));
                    end
                    last_line  = head.addr[31:4];
                    last_valid = 1'b1;
                end
            end
            if (req_valid_i && req_ready_i) begin
                incoming.addr     = req_addr_i;
                incoming.strb     = req_wstrb_i;
                incoming.data     = req_wdata_i;
                incoming.expected = expected_word(req_addr_i);
                incoming.cycle    = cycle;
                // the line of the last completed request is still resident
                incoming.must_hit = (req_wstrb_i == '0) && last_valid &&
                                    (req_addr_i[31:4] == last_line);
                pending.push_back(incoming);
            end
            if (awvalid_i && awready_i) begin
                beat_addr = awaddr_i;
                aw_seen   = 1'b1;
            end
            if (wvalid_i && wready_i) begin
                beat_data = wdata_i;
                beat_strb = wstrb_i;
                w_seen    = 1'b1;
            end
            if (aw_seen && w_seen) begin
                check_count_o++;
                if (beat_addr[1:0] != 2'b00 || beat_strb != 4'hf) begin
                    report_error($sformatf("write beat address %h strobe %b",
                                           beat_addr, beat_strb));
                end
                if (beat_data !== expected_word(beat_addr)) begin
                    report_error($sformatf("write back %h carried %h, expected %h",
                                           beat_addr, beat_data, expected_word(beat_addr)));
                end
                aw_seen = 1'b0;
                w_seen  = 1'b0;
            end
        end
    end

    initial begin
        cycle = '0;
    end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

    localparam int N_REQ          = 400;
    localparam int CLK_PERIOD     = 8;
    localparam int RST_CYCLES     = 10;
    localparam int CYCLES_PER_REQ = 120;
    localparam int TIMEOUT_NS     = N_REQ * CYCLES_PER_REQ * CLK_PERIOD;
    localparam int QUIET_CYCLES   = 200;
    localparam int MAX_DELAY      = 5;
    localparam int N_TAGS         = 8;
    localparam int N_SETS         = 4;
    localparam int TAG_BASE       = 22'h0a5;
    localparam int SEED           = 32'h12f;

    logic              clk = 1'b0;
    logic              rst;
    logic              req_valid_i;
    logic              req_ready_o;
    dcache_pkg::addr_t req_addr_i;
    dcache_pkg::strb_t req_wstrb_i;
    dcache_pkg::word_t req_wdata_i;
    logic              resp_valid_o;
    dcache_pkg::word_t resp_rdata_o;
    logic              awvalid_o;
    logic              awready_i;
    dcache_pkg::addr_t awaddr_o;
    logic              wvalid_o;
    logic              wready_i;
    dcache_pkg::word_t wdata_o;
    dcache_pkg::strb_t wstrb_o;
    logic              bvalid_i;
    logic              bready_o;
    logic              arvalid_o;
    logic              arready_i;
    dcache_pkg::addr_t araddr_o;
    logic              rvalid_i;
    logic              rready_o;
    dcache_pkg::word_t rdata_i;

    int                check_count;
    int                error_count;
    int                resp_count;
    logic [27:0]       prev_line;
    dcache_pkg::word_t mem [logic [29:0]];

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top i_dut (.*);

    dcache_checker i_chk (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_ready_i   (req_ready_o),
        .req_addr_i    (req_addr_i),
        .req_wstrb_i   (req_wstrb_i),
        .req_wdata_i   (req_wdata_i),
        .resp_valid_i  (resp_valid_o),
        .resp_rdata_i  (resp_rdata_o),
        .awvalid_i     (awvalid_o),
        .awready_i     (awready_i),
        .awaddr_i      (awaddr_o),
        .wvalid_i      (wvalid_o),
        .wready_i      (wready_i),
        .wdata_i       (wdata_o),
        .wstrb_i       (wstrb_o),
        .check_count_o (check_count),
        .error_count_o (error_count),
        .resp_count_o  (resp_count)
    );

    function automatic int random_delay();
        return int'($urandom % (MAX_DELAY + 1));
    endfunction

    function automatic dcache_pkg::word_t mem_read(dcache_pkg::addr_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    task automatic mem_write(dcache_pkg::addr_t addr, dcache_pkg::word_t data,
                             dcache_pkg::strb_t strb);
        dcache_pkg::word_t word;
        word = mem_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[addr[31:2]] = word;
    endtask

    // few tags over few sets, so more than two tags compete for a set
    task automatic send_random_request();
        dcache_pkg::addr_t addr;
        dcache_pkg::strb_t strb;
        logic [1:0]        lane;
        int                kind;
        kind = int'($urandom % 8);
        lane = 2'($urandom);
        addr = {dcache_pkg::tag_t'(TAG_BASE + $urandom % N_TAGS),
                dcache_pkg::index_t'($urandom % N_SETS), 2'($urandom), 2'b00};
        if ($urandom % 4 == 0) begin
            addr[31:4] = prev_line;
        end
        if (kind < 4) begin
            strb = 4'b0000;
        end else if (kind == 4) begin
            strb       = 4'b0001 << lane;
            addr[1:0]  = lane;
        end else if (kind == 5) begin
            strb       = lane[1] ? 4'b1100 : 4'b0011;
            addr[1:0]  = {lane[1], 1'b0};
        end else begin
            strb = 4'b1111;
        end
        if ($urandom % 4 == 0) begin
            @(negedge clk);
        end
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_wstrb_i = strb;
        req_wdata_i = $urandom;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
        prev_line   = addr[31:4];
    endtask

    task automatic wait_bus_quiet();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            if (awvalid_o || wvalid_o || arvalid_o || bready_o || rready_o) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    initial begin : read_model
        dcache_pkg::addr_t addr;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rdata_i   = '0;
        forever begin
            @(negedge clk);
            if (!rst && arvalid_o) begin
                repeat (random_delay()) @(negedge clk);
                arready_i = 1'b1;
                addr      = araddr_o;
                @(negedge clk);
                arready_i = 1'b0;
                repeat (random_delay()) @(negedge clk);
                rvalid_i = 1'b1;
                rdata_i  = mem_read(addr);
                while (!rready_o) begin
                    @(negedge clk);
                end
                @(negedge clk);
                rvalid_i = 1'b0;
            end
        end
    end

    initial begin : write_model
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t data;
        dcache_pkg::strb_t strb;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && awvalid_o) begin
                repeat (random_delay()) @(negedge clk);
                awready_i = 1'b1;
                addr      = awaddr_o;
                @(negedge clk);
                awready_i = 1'b0;
                repeat (random_delay()) @(negedge clk);
                wready_i = 1'b1;
                data     = wdata_o;
                strb     = wstrb_o;
                @(negedge clk);
                wready_i = 1'b0;
                mem_write(addr, data, strb);
                repeat (random_delay()) @(negedge clk);
                bvalid_i = 1'b1;
                while (!bready_o) begin
                    @(negedge clk);
                end
                @(negedge clk);
                bvalid_i = 1'b0;
            end
        end
    end

    initial begin : main
        void'($urandom(SEED));
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        prev_line   = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_REQ; i++) begin
            send_random_request();
        end
        wait (resp_count == N_REQ);
        wait_bus_quiet();
        $display("requests %0d, responses %0d, checks %0d, errors %0d",
                 N_REQ, resp_count, check_count, error_count);
        if (error_count == 0 && resp_count == N_REQ) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout after %0d ns with %0d of %0d responses, errors %0d",
                 TIMEOUT_NS, resp_count, N_REQ, error_count);
        $display("Errors found");
        $finish;
    end

endmodule

// File: filelist.f
verilog/dcache_pkg.sv
verilog/wb_if.sv
verilog/refill_if.sv
verilog/dcache_ways.sv
verilog/dcache_ctrl.sv
verilog/writeback_buffer.sv
verilog/axil_master.sv
verilog/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// File: verilog/axil_master.sv
`timescale 1ns/100ps

module axil_master (
    input  logic              clk,
    input  logic              rst,
    refill_if.mst             refill,
    input  logic              empty_i,
    input  dcache_pkg::addr_t head_addr_i,
    input  dcache_pkg::line_t head_line_i,
    output logic              pop_o,
    output logic              awvalid_o,
    input  logic              awready_i,
    output dcache_pkg::addr_t awaddr_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output dcache_pkg::word_t wdata_o,
    output dcache_pkg::strb_t wstrb_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    output dcache_pkg::addr_t araddr_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  dcache_pkg::word_t rdata_i
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_AR,
        M_R,
        M_DONE,
        M_AW,
        M_B
    } mst_state_t;

    mst_state_t                                    state_q;
    logic [$clog2(dcache_pkg::WORDS_PER_LINE)-1:0] word_q;
    logic                                          aw_sent_q;
    logic                                          w_sent_q;
    dcache_pkg::line_t                             fill_q;

    assign arvalid_o = state_q == M_AR;
    assign rready_o  = state_q == M_R;
    assign awvalid_o = (state_q == M_AW) && !aw_sent_q;
    assign wvalid_o  = (state_q == M_AW) && !w_sent_q;
    assign bready_o  = state_q == M_B;

    // entry leaves the buffer with the last write response of its line
    assign pop_o = bready_o && bvalid_i && (&word_q);

    assign araddr_o = {refill.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], word_q, 2'b00};
    assign awaddr_o = {head_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], word_q, 2'b00};
    assign wdata_o  = head_line_i[dcache_pkg::WORD_W*word_q +: dcache_pkg::WORD_W];
    assign wstrb_o  = '1;

    assign refill.done = state_q == M_DONE;
    assign refill.line = fill_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= M_IDLE;
            word_q    <= '0;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
        end else begin
            case (state_q)
                // refill wins, a drain only starts with no refill pending
                M_IDLE: begin
                    word_q <= '0;
                    if (refill.req) begin
                        state_q <= M_AR;
                    end else if (!empty_i) begin
                        state_q <= M_AW;
                    end
                end
                M_AR: begin
                    if (arready_i) begin
                        state_q <= M_R;
                    end
                end
                M_R: begin
                    if (rvalid_i) begin
                        word_q  <= word_q + 1'b1;
                        state_q <= (&word_q) ? M_DONE : M_AR;
                    end
                end
                M_DONE: state_q <= M_IDLE;
                M_AW: begin
                    if ((aw_sent_q || awready_i) && (w_sent_q || wready_i)) begin
                        aw_sent_q <= 1'b0;
                        w_sent_q  <= 1'b0;
                        state_q   <= M_B;
                    end else begin
                        aw_sent_q <= aw_sent_q || awready_i;
                        w_sent_q  <= w_sent_q || wready_i;
                    end
                end
                M_B: begin
                    if (bvalid_i) begin
                        word_q  <= word_q + 1'b1;
                        state_q <= (&word_q) ? M_IDLE : M_AW;
                    end
                end
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rready_o && rvalid_i) begin
            fill_q[dcache_pkg::WORD_W*word_q +: dcache_pkg::WORD_W] <= rdata_i;
        end
    end

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  dcache_pkg::addr_t req_addr_i,
    input  dcache_pkg::strb_t req_wstrb_i,
    input  dcache_pkg::word_t req_wdata_i,
    output logic              req_ready_o,
    output logic              resp_valid_o,
    output dcache_pkg::word_t resp_rdata_o,
    wb_if.ctrl                wb,
    refill_if.ctrl            refill
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_CONFLICT,
        REFILL,
        EVICT
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // stage 2 request
    logic                                    s2_valid_q;
    dcache_pkg::addr_t                       s2_addr_q;
    dcache_pkg::strb_t                       s2_wstrb_q;
    dcache_pkg::word_t                       s2_wdata_q;
    dcache_pkg::tag_t                        s2_tag;
    dcache_pkg::index_t                      s2_index;
    logic [dcache_pkg::OFFSET_W-3:0]         s2_word;
    logic                                    s2_store;
    dcache_pkg::addr_t                       line_addr;

    logic                                    accept;
    logic [dcache_pkg::NWAY-1:0]             tag_hit;
    logic                                    hit;
    dcache_pkg::way_t                        hit_way;
    dcache_pkg::way_t                        victim_q;
    logic                                    victim_dirty;
    logic                                    evict_done;
    logic [15:0]                             lfsr_q;
    dcache_pkg::line_t                       fill_q;
    dcache_pkg::line_t                       fill_merged;
    dcache_pkg::line_t                       store_line;
    dcache_pkg::line_strb_t                  store_strb;

    dcache_pkg::tag_t [dcache_pkg::NWAY-1:0]  rd_tag;
    logic [dcache_pkg::NWAY-1:0]             rd_valid;
    logic [dcache_pkg::NWAY-1:0]             rd_dirty;
    dcache_pkg::line_t [dcache_pkg::NWAY-1:0] rd_line;
    logic                                    wr_en;

    assign s2_tag    = s2_addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign s2_index  = s2_addr_q[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign s2_word   = s2_addr_q[dcache_pkg::OFFSET_W-1:2];
    assign s2_store  = s2_wstrb_q != '0;
    assign line_addr = {s2_addr_q[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                        {dcache_pkg::OFFSET_W{1'b0}}};

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::NWAY; w++) begin
            tag_hit[w] = rd_valid[w] && (rd_tag[w] == s2_tag);
            if (tag_hit[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign hit = s2_valid_q && (state_q == IDLE) && (|tag_hit);

    // a store holds stage 2 for one bubble, a miss until it responds
    assign req_ready_o = !rst && (!s2_valid_q || (hit && !s2_store));
    assign accept      = req_valid_i && req_ready_o;

    // store word replicated across the line, bytes picked by the strobe
    assign store_line = {dcache_pkg::WORDS_PER_LINE{s2_wdata_q}};
    assign store_strb = dcache_pkg::line_strb_t'(s2_wstrb_q) << ((dcache_pkg::WORD_W / 8) * s2_word);

    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            fill_merged[8*b +: 8] = store_strb[b] ? store_line[8*b +: 8] : fill_q[8*b +: 8];
        end
    end

    assign victim_dirty = rd_valid[victim_q] && rd_dirty[victim_q];
    assign evict_done   = (state_q == EVICT) && (!victim_dirty || !wb.full);

    assign resp_valid_o = hit || evict_done;
    assign resp_rdata_o = (state_q == EVICT) ?
                          fill_merged[dcache_pkg::WORD_W*s2_word +: dcache_pkg::WORD_W] :
                          rd_line[hit_way][dcache_pkg::WORD_W*s2_word +: dcache_pkg::WORD_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (s2_valid_q && !(|tag_hit)) begin
                    state_d = WAIT_CONFLICT;
                end
            end
            // line may still sit in the write-back buffer
            WAIT_CONFLICT: begin
                if (!wb.match) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (refill.done) begin
                    state_d = EVICT;
                end
            end
            EVICT: begin
                if (evict_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            s2_valid_q <= 1'b0;
            victim_q   <= '0;
            lfsr_q     <= 16'h0001;
        end else begin
            state_q <= state_d;
            lfsr_q  <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            if (accept) begin
                s2_valid_q <= 1'b1;
            end else if (resp_valid_o) begin
                s2_valid_q <= 1'b0;
            end
            if (state_q == IDLE && state_d == WAIT_CONFLICT) begin
                victim_q <= dcache_pkg::way_t'(lfsr_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s2_addr_q  <= req_addr_i;
            s2_wstrb_q <= req_wstrb_i;
            s2_wdata_q <= req_wdata_i;
        end
        if (refill.done) begin
            fill_q <= refill.line;
        end
    end

    assign refill.req  = state_q == REFILL;
    assign refill.addr = line_addr;

    // ways keep the victim on their read port until the next accept
    assign wb.push        = (state_q == EVICT) && victim_dirty;
    assign wb.addr        = {rd_tag[victim_q], s2_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wb.line        = rd_line[victim_q];
    assign wb.lookup_addr = line_addr;

    assign wr_en = (hit && s2_store) || (state_q == EVICT);

    dcache_ways i_ways (
        .clk        (clk),
        .rst        (rst),
        .rd_en_i    (accept),
        .rd_index_i (req_addr_i[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W]),
        .rd_tag_o   (rd_tag),
        .rd_valid_o (rd_valid),
        .rd_dirty_o (rd_dirty),
        .rd_line_o  (rd_line),
        .wr_en_i    (wr_en),
        .wr_way_i   ((state_q == EVICT) ? victim_q : hit_way),
        .wr_index_i (s2_index),
        .wr_tag_i   (s2_tag),
        .wr_dirty_i (s2_store),
        .wr_line_i  ((state_q == EVICT) ? fill_merged : store_line),
        .wr_strb_i  ((state_q == EVICT) ? {dcache_pkg::LINE_BYTES{1'b1}} : store_strb)
    );

endmodule

// File: verilog/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = LINE_BYTES / (WORD_W / 8);
    localparam int OFFSET_W       = $clog2(LINE_BYTES);
    localparam int NSET           = 64;
    localparam int INDEX_W        = $clog2(NSET);
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NWAY           = 2;
    localparam int WB_DEPTH       = 4;

    typedef logic [ADDR_W-1:0]         addr_t;
    typedef logic [WORD_W-1:0]         word_t;
    typedef logic [WORD_W/8-1:0]       strb_t;
    typedef logic [8*LINE_BYTES-1:0]   line_t;
    typedef logic [LINE_BYTES-1:0]     line_strb_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [$clog2(NWAY)-1:0]   way_t;

endpackage

// File: verilog/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic              clk,
    input  logic              rst,
    // cpu port
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  dcache_pkg::addr_t req_addr_i,
    input  dcache_pkg::strb_t req_wstrb_i,
    input  dcache_pkg::word_t req_wdata_i,
    output logic              resp_valid_o,
    output dcache_pkg::word_t resp_rdata_o,
    // axi4-lite master port
    output logic              awvalid_o,
    input  logic              awready_i,
    output dcache_pkg::addr_t awaddr_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output dcache_pkg::word_t wdata_o,
    output dcache_pkg::strb_t wstrb_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    output dcache_pkg::addr_t araddr_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  dcache_pkg::word_t rdata_i
);

    logic              wb_empty;
    dcache_pkg::addr_t wb_head_addr;
    dcache_pkg::line_t wb_head_line;
    logic              wb_pop;

    wb_if     wb_bus ();
    refill_if refill_bus ();

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_addr_i   (req_addr_i),
        .req_wstrb_i  (req_wstrb_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .wb           (wb_bus.ctrl),
        .refill       (refill_bus.ctrl)
    );

    writeback_buffer i_wbuf (
        .clk         (clk),
        .rst         (rst),
        .wb          (wb_bus.buffer),
        .empty_o     (wb_empty),
        .head_addr_o (wb_head_addr),
        .head_line_o (wb_head_line),
        .pop_i       (wb_pop)
    );

    axil_master i_axil (
        .clk         (clk),
        .rst         (rst),
        .refill      (refill_bus.mst),
        .empty_i     (wb_empty),
        .head_addr_i (wb_head_addr),
        .head_line_i (wb_head_line),
        .pop_o       (wb_pop),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .awaddr_o    (awaddr_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .wdata_o     (wdata_o),
        .wstrb_o     (wstrb_o),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .araddr_o    (araddr_o),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .rdata_i     (rdata_i)
    );

endmodule

// File: verilog/dcache_ways.sv
`timescale 1ns/100ps

module dcache_ways (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   rd_en_i,
    input  dcache_pkg::index_t                     rd_index_i,
    output dcache_pkg::tag_t [dcache_pkg::NWAY-1:0]  rd_tag_o,
    output logic [dcache_pkg::NWAY-1:0]            rd_valid_o,
    output logic [dcache_pkg::NWAY-1:0]            rd_dirty_o,
    output dcache_pkg::line_t [dcache_pkg::NWAY-1:0] rd_line_o,
    input  logic                                   wr_en_i,
    input  dcache_pkg::way_t                       wr_way_i,
    input  dcache_pkg::index_t                     wr_index_i,
    input  dcache_pkg::tag_t                       wr_tag_i,
    input  logic                                   wr_dirty_i,
    input  dcache_pkg::line_t                      wr_line_i,
    input  dcache_pkg::line_strb_t                 wr_strb_i
);

    dcache_pkg::tag_t  tag_mem  [dcache_pkg::NWAY][dcache_pkg::NSET];
    dcache_pkg::line_t line_mem [dcache_pkg::NWAY][dcache_pkg::NSET];

    logic [dcache_pkg::NWAY-1:0][dcache_pkg::NSET-1:0] valid_q;
    logic [dcache_pkg::NWAY-1:0][dcache_pkg::NSET-1:0] dirty_q;

    // read port registered on rd_en_i and held otherwise
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
            for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
                if (wr_strb_i[b]) begin
                    line_mem[wr_way_i][wr_index_i][8*b +: 8] <= wr_line_i[8*b +: 8];
                end
            end
        end
        if (rd_en_i) begin
            for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                rd_tag_o[w]  <= tag_mem[w][rd_index_i];
                rd_line_o[w] <= line_mem[w][rd_index_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_o <= '0;
            rd_dirty_o <= '0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_way_i][wr_index_i] <= 1'b1;
                dirty_q[wr_way_i][wr_index_i] <= wr_dirty_i;
            end
            if (rd_en_i) begin
                for (int w = 0; w < dcache_pkg::NWAY; w++) begin
                    rd_valid_o[w] <= valid_q[w][rd_index_i];
                    rd_dirty_o[w] <= dirty_q[w][rd_index_i];
                end
            end
        end
    end

endmodule

// File: verilog/refill_if.sv
`timescale 1ns/100ps

// line refill requests from the controller to the bus master
interface refill_if;
    logic              req;
    dcache_pkg::addr_t addr;
    logic              done;
    dcache_pkg::line_t line;

    modport ctrl (output req, addr, input done, line);
    modport mst (input req, addr, output done, line);
endinterface

// File: verilog/wb_if.sv
`timescale 1ns/100ps

// victim lines from the controller into the write-back buffer
interface wb_if;
    logic              push;
    dcache_pkg::addr_t addr;
    dcache_pkg::line_t line;
    logic              full;
    dcache_pkg::addr_t lookup_addr;
    logic              match;

    modport ctrl (output push, addr, line, lookup_addr, input full, match);
    modport buffer (input push, addr, line, lookup_addr, output full, match);
endinterface

// File: verilog/writeback_buffer.sv
`timescale 1ns/100ps

module writeback_buffer (
    input  logic              clk,
    input  logic              rst,
    wb_if.buffer              wb,
    output logic              empty_o,
    output dcache_pkg::addr_t head_addr_o,
    output dcache_pkg::line_t head_line_o,
    input  logic              pop_i
);

    dcache_pkg::addr_t addr_mem [dcache_pkg::WB_DEPTH];
    dcache_pkg::line_t line_mem [dcache_pkg::WB_DEPTH];

    logic [$clog2(dcache_pkg::WB_DEPTH)-1:0] head_q;
    logic [$clog2(dcache_pkg::WB_DEPTH)-1:0] tail_q;
    logic [$clog2(dcache_pkg::WB_DEPTH)-1:0] rel;
    logic [$clog2(dcache_pkg::WB_DEPTH):0]   count_q;
    logic                                    do_push;

    assign do_push     = wb.push && !wb.full;
    assign wb.full     = count_q == dcache_pkg::WB_DEPTH;
    assign empty_o     = count_q == '0;
    assign head_addr_o = addr_mem[head_q];
    assign head_line_o = line_mem[head_q];

    // entry i is live when its distance from head is below the count
    always_comb begin
        wb.match = 1'b0;
        rel      = '0;
        for (int i = 0; i < dcache_pkg::WB_DEPTH; i++) begin
            rel = i[$clog2(dcache_pkg::WB_DEPTH)-1:0] - head_q;
            if (({1'b0, rel} < count_q) && (addr_mem[i] == wb.lookup_addr)) begin
                wb.match = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (do_push && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[tail_q] <= wb.addr;
            line_mem[tail_q] <= wb.line;
        end
    end

endmodule
